// File: hdl/kill_pkg.sv
`default_nettype none

package kill_pkg;

    localparam int BOARD_N = 15;
    localparam int CELLS   = BOARD_N * BOARD_N;

    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_BLACK = 2'd1,  // attacker
        CELL_WHITE = 2'd2,  // defender
        CELL_BLOCK = 2'd3   // off-board cells in windows only
    } cell_t;

    typedef cell_t [CELLS-1:0] board_t;  // row * BOARD_N + col

    typedef logic [7:0] pos_t;

    typedef cell_t [8:0] window_t;  // [4] is the probe cell

    typedef struct packed {
        logic             valid;
        logic             last;
        pos_t             pos;
        window_t [3:0]    win;  // horiz, vert, diag, anti-diag
    } probe_t;

    typedef struct packed {
        logic valid;
        logic last;
        pos_t pos;
        logic is_five;
        logic is_four;
        pos_t block_pos;
    } eval_t;

    typedef struct packed {
        logic valid;
        logic has_five;
        pos_t five_pos;
        logic has_four;
        pos_t four_pos;
        pos_t block_pos;
    } scan_result_t;

    typedef struct packed {
        logic apply;
        pos_t atk_pos;
        pos_t def_pos;
    } ply_t;

endpackage

`default_nettype wire

// File: hdl/board_update.sv
`timescale 1ns/1ps
`default_nettype none

module board_update (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_load,
    input  kill_pkg::board_t  i_board,
    input  kill_pkg::ply_t    i_ply,
    output kill_pkg::board_t  o_board
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < kill_pkg::CELLS; i++) begin
                o_board[i] <= kill_pkg::CELL_EMPTY;
            end
        end else if (i_load) begin
            o_board <= i_board;  // fresh position for a new search
        end else if (i_ply.apply) begin
            o_board[i_ply.atk_pos] <= kill_pkg::CELL_BLACK;  // the four
            o_board[i_ply.def_pos] <= kill_pkg::CELL_WHITE;  // forced reply
        end
    end

endmodule

`default_nettype wire

// File: hdl/cell_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module cell_scanner (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_go,
    input  kill_pkg::board_t  i_board,
    output kill_pkg::probe_t  o_probe
);

    // row and column step of each direction
    localparam int DR [0:3] = '{0, 1, 1, 1};
    localparam int DC [0:3] = '{1, 0, 1, -1};

    logic                    busy_r;
    kill_pkg::pos_t          cnt_r;
    logic [3:0]              row_r;
    logic [3:0]              col_r;
    logic                    active;
    kill_pkg::pos_t          cur_pos;
    logic [3:0]              cur_row;
    logic [3:0]              cur_col;
    logic                    cur_last;
    kill_pkg::window_t [3:0] cur_win;

    assign active   = i_go || busy_r;
    assign cur_pos  = busy_r ? cnt_r : '0;  // cell 0 on the go cycle
    assign cur_row  = busy_r ? row_r : '0;
    assign cur_col  = busy_r ? col_r : '0;
    assign cur_last = (cur_pos == kill_pkg::pos_t'(kill_pkg::CELLS - 1));

    always_comb begin
        int rr;
        int cc;
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < 9; k++) begin
                rr = int'(cur_row) + (k - 4) * DR[d];
                cc = int'(cur_col) + (k - 4) * DC[d];
                if (rr >= 0 && rr < kill_pkg::BOARD_N &&
                    cc >= 0 && cc < kill_pkg::BOARD_N) begin
                    cur_win[d][k] = i_board[rr * kill_pkg::BOARD_N + cc];
                end else begin
                    cur_win[d][k] = kill_pkg::CELL_BLOCK;  // no wrap across rows
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r  <= 1'b0;
            cnt_r   <= '0;
            row_r   <= '0;
            col_r   <= '0;
            o_probe <= '0;
        end else begin
            o_probe.valid <= active;
            o_probe.last  <= active && cur_last;
            if (active) begin
                busy_r      <= !cur_last;
                cnt_r       <= cur_pos + 8'd1;
                o_probe.pos <= cur_pos;
                o_probe.win <= cur_win;
                if (cur_col == 4'(kill_pkg::BOARD_N - 1)) begin
                    col_r <= '0;
                    row_r <= cur_row + 4'd1;
                end else begin
                    col_r <= cur_col + 4'd1;
                    row_r <= cur_row;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/threat_eval.sv
`timescale 1ns/1ps
`default_nettype none

module threat_eval #(
    parameter int WIN_LEN = 5
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  kill_pkg::probe_t  i_probe,
    output kill_pkg::eval_t   o_eval
);

    // index distance of one step along each direction
    localparam int STEP [0:3] = '{1, kill_pkg::BOARD_N, kill_pkg::BOARD_N + 1,
                                  kill_pkg::BOARD_N - 1};

    logic           five;
    logic           four;
    kill_pkg::pos_t blk;

    always_comb begin
        int              lcnt;
        int              rcnt;
        logic            lstop;
        logic            rstop;
        kill_pkg::cell_t lo_end;
        kill_pkg::cell_t hi_end;
        five = 1'b0;
        four = 1'b0;
        blk  = '0;
        for (int d = 0; d < 4; d++) begin
            lcnt  = 0;
            rcnt  = 0;
            lstop = 1'b0;
            rstop = 1'b0;
            for (int k = 1; k <= 4; k++) begin
                if (!lstop && i_probe.win[d][4-k] == kill_pkg::CELL_BLACK) begin
                    lcnt++;
                end else begin
                    lstop = 1'b1;
                end
                if (!rstop && i_probe.win[d][4+k] == kill_pkg::CELL_BLACK) begin
                    rcnt++;
                end else begin
                    rstop = 1'b1;
                end
            end
            lo_end = (lcnt < 4) ? i_probe.win[d][3-lcnt] : kill_pkg::CELL_BLOCK;
            hi_end = (rcnt < 4) ? i_probe.win[d][5+rcnt] : kill_pkg::CELL_BLOCK;
            if (lcnt + rcnt + 1 >= WIN_LEN) begin
                five = 1'b1;  // overlines count too
            end else if (!four && lcnt + rcnt + 1 == WIN_LEN - 1) begin
                if (lo_end == kill_pkg::CELL_EMPTY) begin
                    four = 1'b1;
                    blk  = kill_pkg::pos_t'(int'(i_probe.pos) - (lcnt + 1) * STEP[d]);
                end else if (hi_end == kill_pkg::CELL_EMPTY) begin
                    four = 1'b1;
                    blk  = kill_pkg::pos_t'(int'(i_probe.pos) + (rcnt + 1) * STEP[d]);
                end
            end
        end
        if (i_probe.win[0][4] != kill_pkg::CELL_EMPTY) begin
            five = 1'b0;  // occupied cell is no move
            four = 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_eval <= '0;
        end else begin
            o_eval.valid     <= i_probe.valid;
            o_eval.last      <= i_probe.last;
            o_eval.pos       <= i_probe.pos;
            o_eval.is_five   <= i_probe.valid && five;
            o_eval.is_four   <= i_probe.valid && four;
            o_eval.block_pos <= blk;
        end
    end

endmodule

`default_nettype wire

// File: hdl/threat_select.sv
`timescale 1ns/1ps
`default_nettype none

module threat_select (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  kill_pkg::eval_t         i_eval,
    output kill_pkg::scan_result_t  o_result
);

    logic           five_r;
    kill_pkg::pos_t five_pos_r;
    logic           four_r;
    kill_pkg::pos_t four_pos_r;
    kill_pkg::pos_t blk_r;
    logic           nxt_five;
    kill_pkg::pos_t nxt_five_pos;
    logic           nxt_four;
    kill_pkg::pos_t nxt_four_pos;
    kill_pkg::pos_t nxt_blk;

    always_comb begin
        nxt_five     = five_r;
        nxt_five_pos = five_pos_r;
        nxt_four     = four_r;
        nxt_four_pos = four_pos_r;
        nxt_blk      = blk_r;
        if (i_eval.valid) begin
            if (i_eval.pos == '0) begin
                nxt_five = 1'b0;  // new scan
                nxt_four = 1'b0;
            end
            if (i_eval.is_five && !nxt_five) begin
                nxt_five     = 1'b1;
                nxt_five_pos = i_eval.pos;
            end
            if (i_eval.is_four && !nxt_four) begin
                nxt_four     = 1'b1;
                nxt_four_pos = i_eval.pos;
                nxt_blk      = i_eval.block_pos;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            five_r     <= 1'b0;
            five_pos_r <= '0;
            four_r     <= 1'b0;
            four_pos_r <= '0;
            blk_r      <= '0;
            o_result   <= '0;
        end else begin
            five_r         <= nxt_five;
            five_pos_r     <= nxt_five_pos;
            four_r         <= nxt_four;
            four_pos_r     <= nxt_four_pos;
            blk_r          <= nxt_blk;
            o_result.valid <= i_eval.valid && i_eval.last;
            if (i_eval.valid && i_eval.last) begin
                o_result.has_five  <= nxt_five;
                o_result.five_pos  <= nxt_five_pos;
                o_result.has_four  <= nxt_four;
                o_result.four_pos  <= nxt_four_pos;
                o_result.block_pos <= nxt_blk;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/kill_control.sv
`timescale 1ns/1ps
`default_nettype none

module kill_control (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic [4:0]              i_depth,
    input  kill_pkg::scan_result_t  i_result,
    output logic                    o_load,
    output logic                    o_scan_go,
    output kill_pkg::ply_t          o_ply,
    output logic                    o_sha,
    output logic                    o_finish,
    output kill_pkg::pos_t          o_win_pos
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_APPLY,
        ST_DONE
    } state_t;

    state_t     state_r;
    logic [4:0] depth_r;
    logic [4:0] plies_r;  // fours played so far

    assign o_load = (state_r == ST_IDLE) && i_start;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= ST_IDLE;
            depth_r   <= '0;
            plies_r   <= '0;
            o_scan_go <= 1'b0;
            o_ply     <= '0;
            o_sha     <= 1'b0;
            o_finish  <= 1'b0;
            o_win_pos <= '0;
        end else begin
            o_scan_go   <= 1'b0;
            o_ply.apply <= 1'b0;
            o_finish    <= 1'b0;
            case (state_r)
                ST_IDLE: begin
                    if (i_start) begin
                        depth_r   <= i_depth;
                        plies_r   <= '0;
                        o_sha     <= 1'b0;
                        o_win_pos <= '0;
                        o_scan_go <= 1'b1;  // board loads on this edge
                        state_r   <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (i_result.valid) begin
                        if (i_result.has_five) begin
                            o_sha     <= 1'b1;
                            o_win_pos <= i_result.five_pos;
                            o_finish  <= 1'b1;
                            state_r   <= ST_DONE;
                        end else if (!i_result.has_four || plies_r >= depth_r) begin
                            o_finish <= 1'b1;  // no forcing line left
                            state_r  <= ST_DONE;
                        end else begin
                            o_ply.apply   <= 1'b1;
                            o_ply.atk_pos <= i_result.four_pos;
                            o_ply.def_pos <= i_result.block_pos;
                            plies_r       <= plies_r + 5'd1;
                            state_r       <= ST_APPLY;
                        end
                    end
                end
                ST_APPLY: begin
                    o_scan_go <= 1'b1;  // board updated by now
                    state_r   <= ST_SCAN;
                end
                default: begin
                    state_r <= ST_IDLE;  // finish strobe cycle
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/kill_search_top.sv
`timescale 1ns/1ps
`default_nettype none

module kill_search_top #(
    parameter int WIN_LEN = 5
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic [4:0]           i_depth,
    input  kill_pkg::board_t     i_board,
    output logic                 o_sha,
    output logic                 o_finish,
    output kill_pkg::pos_t       o_win_pos
);

    logic                   load;
    logic                   scan_go;
    kill_pkg::ply_t         ply;
    kill_pkg::board_t       board;
    kill_pkg::probe_t       probe;
    kill_pkg::eval_t        eval;
    kill_pkg::scan_result_t result;

    board_update u_board_update (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_load  (load),
        .i_board (i_board),
        .i_ply   (ply),
        .o_board (board)
    );

    cell_scanner u_cell_scanner (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_go    (scan_go),
        .i_board (board),
        .o_probe (probe)
    );

    threat_eval #(
        .WIN_LEN (WIN_LEN)
    ) u_threat_eval (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_probe (probe),
        .o_eval  (eval)
    );

    threat_select u_threat_select (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_eval   (eval),
        .o_result (result)
    );

    kill_control u_kill_control (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (i_start),
        .i_depth   (i_depth),
        .i_result  (result),
        .o_load    (load),
        .o_scan_go (scan_go),
        .o_ply     (ply),
        .o_sha     (o_sha),
        .o_finish  (o_finish),
        .o_win_pos (o_win_pos)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;  // released off the edge
    end

endmodule

`default_nettype wire

// File: test/tb_result_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_result_checker (
    input  logic            i_clk,
    input  logic            i_finish,
    input  logic            i_sha,
    input  kill_pkg::pos_t  i_win_pos,
    input  logic            i_arm,
    input  logic            i_close,
    input  int              i_test_num,
    input  logic            i_exp_sha,
    input  kill_pkg::pos_t  i_exp_pos,
    output int              o_pass_cnt,
    output int              o_fail_cnt
);

    int             pass_cnt   = 0;
    int             fail_cnt   = 0;
    int             finish_cnt = 0;
    int             num_r      = 0;
    logic           armed      = 1'b0;
    logic           bad        = 1'b0;
    logic           exp_sha_r  = 1'b0;
    kill_pkg::pos_t exp_pos_r  = '0;

    assign o_pass_cnt = pass_cnt;
    assign o_fail_cnt = fail_cnt;

    always @(posedge i_clk) begin
        if (i_finish) begin
            if (!armed) begin
                $display("o_finish pulsed while no test was running");
                fail_cnt = fail_cnt + 1;
            end else begin
                finish_cnt = finish_cnt + 1;
                if (finish_cnt > 1) begin
                    $display("test %0d: more than one o_finish for a single start", num_r);
                    bad = 1'b1;
                end else begin
                    if (i_sha !== exp_sha_r) begin
                        $display("MISMATCH test %0d: o_sha got %h expected %h",
                                 num_r, i_sha, exp_sha_r);
                        bad = 1'b1;
                    end
                    if (i_win_pos !== exp_pos_r) begin
                        $display("MISMATCH test %0d: o_win_pos got %h expected %h",
                                 num_r, i_win_pos, exp_pos_r);
                        bad = 1'b1;
                    end
                end
            end
        end
        if (i_close && armed) begin
            if (finish_cnt == 0) begin
                $display("test %0d: o_finish never came within the cycle limit", num_r);
                bad = 1'b1;
            end
            if (bad) begin
                $display("test %0d FAIL", num_r);
                fail_cnt = fail_cnt + 1;
            end else begin
                $display("test %0d pass", num_r);
                pass_cnt = pass_cnt + 1;
            end
            armed = 1'b0;
        end
        if (i_arm) begin
            armed      = 1'b1;  // new search starts this cycle
            bad        = 1'b0;
            finish_cnt = 0;
            num_r      = i_test_num;
            exp_sha_r  = i_exp_sha;
            exp_pos_r  = i_exp_pos;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_kill_search.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kill_search;

    localparam int CLK_NS      = 4;
    localparam int NUM_TESTS   = 10;
    localparam int WAIT_LIMIT  = 32 * 240;  // plies times cycles per ply
    localparam int WATCHDOG_NS = NUM_TESTS * WAIT_LIMIT * CLK_NS + 100 * CLK_NS;

    // stone 12'hCRK holds color (1 black, 2 white or 0 for none), row and column
    typedef struct packed {
        logic [7:0][11:0] stones;
        logic [4:0]       depth;
        logic             exp_sha;
        kill_pkg::pos_t   exp_pos;
        logic             restart;  // second start while busy
        logic             no_gap;   // starts right after the previous test
    } test_t;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [4:0]       depth;
    kill_pkg::board_t board;
    logic             sha;
    logic             finish;
    kill_pkg::pos_t   win_pos;
    logic             arm;
    logic             close;
    int               test_num;
    logic             exp_sha;
    kill_pkg::pos_t   exp_pos;
    int               pass_cnt;
    int               fail_cnt;
    logic [31:0]      lfsr;
    test_t            tests [NUM_TESTS];

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    kill_search_top #(.WIN_LEN(5)) UUT (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_start   (start),
        .i_depth   (depth),
        .i_board   (board),
        .o_sha     (sha),
        .o_finish  (finish),
        .o_win_pos (win_pos)
    );

    tb_result_checker u_result_checker (
        .i_clk      (clk),
        .i_finish   (finish),
        .i_sha      (sha),
        .i_win_pos  (win_pos),
        .i_arm      (arm),
        .i_close    (close),
        .i_test_num (test_num),
        .i_exp_sha  (exp_sha),
        .i_exp_pos  (exp_pos),
        .o_pass_cnt (pass_cnt),
        .o_fail_cnt (fail_cnt)
    );

    function automatic kill_pkg::board_t build_board(input logic [7:0][11:0] stones);
        kill_pkg::board_t b;
        kill_pkg::pos_t   idx;
        for (int i = 0; i < kill_pkg::CELLS; i++) begin
            b[i] = kill_pkg::CELL_EMPTY;
        end
        for (int s = 0; s < 8; s++) begin
            if (stones[s][11:8] != 4'd0) begin
                idx = kill_pkg::pos_t'(int'(stones[s][7:4]) * kill_pkg::BOARD_N
                                       + int'(stones[s][3:0]));
                b[idx] = (stones[s][11:8] == 4'd1) ? kill_pkg::CELL_BLACK
                                                   : kill_pkg::CELL_WHITE;
            end
        end
        return b;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int cycles);
        cycles = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr   = lfsr_next(lfsr);
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic run_test(input int n);
        int   gap;
        int   waited;
        logic seen;
        gap = 0;
        if (!tests[n].no_gap) begin
            draw_gap(gap);
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        board    = build_board(tests[n].stones);
        depth    = tests[n].depth;
        test_num = n;
        exp_sha  = tests[n].exp_sha;
        exp_pos  = tests[n].exp_pos;
        start    = 1'b1;
        arm      = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        arm    = 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (tests[n].restart && waited == 4) begin
                board = build_board('0);  // would end at once if taken
                depth = 5'd0;
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            seen = finish;
        end
        @(posedge clk);
        #1;
        close = 1'b1;
        @(posedge clk);
        #1;
        close = 1'b0;
    endtask

    initial begin
        start    = 1'b0;
        depth    = '0;
        board    = build_board('0);
        arm      = 1'b0;
        close    = 1'b0;
        test_num = 0;
        exp_sha  = 1'b0;
        exp_pos  = '0;
        lfsr     = 32'h4508;
        // stones, depth, sha, win pos, restart, no gap
        tests[0] = {{12'h170, 12'h171, 12'h172, 12'h173, 48'h0}, 5'd0, 1'b1, 8'd109, 2'b00};
        tests[1] = {96'h0, 5'd5, 1'b0, 8'd0, 2'b00};
        tests[2] = {{12'h100, 12'h125, 12'h177, 12'h1A3, 12'h244, 12'h1CC, 24'h0},
                    5'd4, 1'b0, 8'd0, 2'b00};
        tests[3] = {{12'h153, 12'h154, 12'h155, 12'h166, 12'h176, 12'h252, 24'h0},
                    5'd2, 1'b1, 8'd126, 2'b00};
        tests[4] = {{12'h153, 12'h154, 12'h155, 12'h166, 12'h176, 12'h252, 24'h0},
                    5'd1, 1'b0, 8'd0, 2'b00};
        tests[5] = {{12'h22A, 12'h12B, 12'h12C, 12'h12D, 12'h12E, 36'h0},
                    5'd3, 1'b0, 8'd0, 2'b00};
        tests[6] = {{12'h13C, 12'h13D, 12'h13E, 12'h140, 48'h0}, 5'd1, 1'b0, 8'd0, 2'b00};
        tests[7] = {{12'h1EA, 12'h1EB, 12'h1EC, 12'h1ED, 48'h0}, 5'd0, 1'b1, 8'd219, 2'b00};
        tests[8] = {{12'h153, 12'h154, 12'h155, 12'h166, 12'h176, 12'h252, 24'h0},
                    5'd2, 1'b1, 8'd126, 2'b10};
        tests[9] = {{12'h209, 12'h10A, 12'h10B, 12'h10C, 12'h10D, 36'h0},
                    5'd0, 1'b1, 8'd14, 2'b01};
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end
        repeat (2) @(posedge clk);
        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the test list ended", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: kill_search.f
hdl/kill_pkg.sv
hdl/board_update.sv
hdl/cell_scanner.sv
hdl/threat_eval.sv
hdl/threat_select.sv
hdl/kill_control.sv
hdl/kill_search_top.sv
test/tb_clock_gen.sv
test/tb_result_checker.sv
test/tb_kill_search.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_kill_search \
    -Mdir obj_dir -f kill_search.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_kill_search)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
